// File: src/tank_pkg.sv
`default_nettype none

package tank_pkg;

	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;
	localparam int COORD_W = 8;
	localparam int COLOUR_W = 3;

	localparam int TANK_W = 16;
	localparam int TANK_H = 16;
	localparam int GUN_W = 4;
	localparam int GUN_H = 4;
	localparam int BULLET_W = 4;
	localparam int BULLET_H = 2;
	localparam int BULLET_STEP = 2;

	localparam int SCORE_W = 4;
	localparam int WIN_SCORE = 7;
	localparam int NUM_PLAYERS = 2;

	localparam logic [COLOUR_W-1:0] COLOUR_BLACK = 3'b000;
	localparam logic [COLOUR_W-1:0] COLOUR_HIT = 3'b101;	// Magenta flash

	// Index 0 is the right player, index 1 the left player
	localparam logic [COLOUR_W-1:0] PLAYER_COLOUR [NUM_PLAYERS] = '{3'b011, 3'b001};
	localparam int START_X [NUM_PLAYERS] = '{144, 8};
	localparam int START_Y [NUM_PLAYERS] = '{50, 50};
	localparam int MIN_X [NUM_PLAYERS] = '{123, 8};
	localparam int MAX_X [NUM_PLAYERS] = '{144, 30};
	localparam int MIN_Y [NUM_PLAYERS] = '{10, 10};
	localparam int MAX_Y [NUM_PLAYERS] = '{100, 100};
	localparam int GUN_DX [NUM_PLAYERS] = '{-GUN_W, TANK_W};	// Gun sits on the facing side
	localparam int GUN_DY [NUM_PLAYERS] = '{6, 6};
	localparam int FIRE_DIR [NUM_PLAYERS] = '{-1, 1};

	localparam int KEY_W = 7;

	localparam logic [KEY_W-1:0] KEY_R_UP = 7'h11;
	localparam logic [KEY_W-1:0] KEY_R_LEFT = 7'h12;
	localparam logic [KEY_W-1:0] KEY_R_DOWN = 7'h13;
	localparam logic [KEY_W-1:0] KEY_R_RIGHT = 7'h14;
	localparam logic [KEY_W-1:0] KEY_R_FIRE = 7'h15;

	// ASCII w, a, s, d, f
	localparam logic [KEY_W-1:0] KEY_L_UP = 7'h77;
	localparam logic [KEY_W-1:0] KEY_L_LEFT = 7'h61;
	localparam logic [KEY_W-1:0] KEY_L_DOWN = 7'h73;
	localparam logic [KEY_W-1:0] KEY_L_RIGHT = 7'h64;
	localparam logic [KEY_W-1:0] KEY_L_FIRE = 7'h66;

	typedef enum logic [2:0] {NONE, UP, DOWN, LEFT, RIGHT} move_t;

	typedef enum logic [2:0] {CLEAR, IDLE, ERASE, STEP, DRAW} render_state_t;

endpackage

`default_nettype wire

// File: src/key_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module key_decoder import tank_pkg::*; (
	input wire CLOCK_50,
	input wire reset,
	input wire key_req,
	input wire [KEY_W-1:0] key_code,
	input wire step,
	output logic key_ack,
	output move_t [NUM_PLAYERS-1:0] move,
	output logic [NUM_PLAYERS-1:0] fire
);

	logic dec_valid;
	logic dec_player;
	logic dec_fire;
	move_t dec_move;
	logic accept;

	assign accept = key_req && !key_ack;	// New code on the bus

	always_comb begin
		dec_valid = 1'b1;
		dec_player = 1'b0;
		dec_fire = 1'b0;
		dec_move = NONE;
		case (key_code)
			KEY_R_UP: dec_move = UP;
			KEY_R_DOWN: dec_move = DOWN;
			KEY_R_LEFT: dec_move = LEFT;
			KEY_R_RIGHT: dec_move = RIGHT;
			KEY_R_FIRE: dec_fire = 1'b1;
			KEY_L_UP: {dec_player, dec_move} = {1'b1, UP};
			KEY_L_DOWN: {dec_player, dec_move} = {1'b1, DOWN};
			KEY_L_LEFT: {dec_player, dec_move} = {1'b1, LEFT};
			KEY_L_RIGHT: {dec_player, dec_move} = {1'b1, RIGHT};
			KEY_L_FIRE: {dec_player, dec_fire} = 2'b11;
			default: dec_valid = 1'b0;	// Acked but dropped
		endcase
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			key_ack <= 1'b0;
			move <= {NUM_PLAYERS{NONE}};
			fire <= '0;
		end else begin
			if (accept)
				key_ack <= 1'b1;
			else if (!key_req)
				key_ack <= 1'b0;

			// Commands consumed by the step, a key in the same cycle still lands
			if (step) begin
				move <= {NUM_PLAYERS{NONE}};
				fire <= '0;
			end
			if (accept && dec_valid) begin
				if (dec_fire)
					fire[dec_player] <= 1'b1;
				else
					move[dec_player] <= dec_move;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/tank_player.sv
`timescale 1ns/10ps
`default_nettype none

module tank_player import tank_pkg::*; #(
	parameter int PLAYER = 0
) (
	input wire CLOCK_50,
	input wire reset,
	input wire step,
	input wire new_game,
	input wire move_t move,
	input wire fire,
	input wire [COORD_W-1:0] opp_x,
	input wire [COORD_W-1:0] opp_y,
	output logic [COORD_W-1:0] tank_x,
	output logic [COORD_W-1:0] tank_y,
	output logic [COORD_W-1:0] bullet_x,
	output logic [COORD_W-1:0] bullet_y,
	output logic bullet_live,
	output logic hit,
	output logic [SCORE_W-1:0] score,
	output logic win
);

	logic [COORD_W-1:0] tx_n, ty_n;
	logic [COORD_W-1:0] gun_x, gun_y;
	logic leaving, strike;
	int bx_next;

	always_comb begin
		tx_n = tank_x;
		ty_n = tank_y;
		case (move)
			UP: if (tank_y > MIN_Y[PLAYER]) ty_n = tank_y - 1'b1;
			DOWN: if (tank_y < MAX_Y[PLAYER]) ty_n = tank_y + 1'b1;
			LEFT: if (tank_x > MIN_X[PLAYER]) tx_n = tank_x - 1'b1;
			RIGHT: if (tank_x < MAX_X[PLAYER]) tx_n = tank_x + 1'b1;
			default: ;
		endcase
		gun_x = COORD_W'(int'(tx_n) + GUN_DX[PLAYER]);
		gun_y = COORD_W'(int'(ty_n) + GUN_DY[PLAYER]);
	end

	// Bullet flight and overlap against the opponent's tank box
	always_comb begin
		bx_next = int'(bullet_x) + FIRE_DIR[PLAYER] * BULLET_STEP;
		leaving = (bx_next < 0) || (bx_next + BULLET_W > SCREEN_W);
		strike = (bx_next < int'(opp_x) + TANK_W) &&
			(bx_next + BULLET_W > int'(opp_x)) &&
			(int'(bullet_y) < int'(opp_y) + TANK_H) &&
			(int'(bullet_y) + BULLET_H > int'(opp_y));
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset || new_game) begin
			tank_x <= COORD_W'(START_X[PLAYER]);
			tank_y <= COORD_W'(START_Y[PLAYER]);
			bullet_x <= COORD_W'(START_X[PLAYER] + GUN_DX[PLAYER]);
			bullet_y <= COORD_W'(START_Y[PLAYER] + GUN_DY[PLAYER]);
			bullet_live <= 1'b0;
			hit <= 1'b0;
			score <= '0;
		end else if (step) begin
			tank_x <= tx_n;
			tank_y <= ty_n;
			hit <= 1'b0;
			if (bullet_live && !leaving && !strike) begin
				bullet_x <= COORD_W'(bx_next);
			end else begin
				// Idle bullet rides along with the gun
				bullet_x <= gun_x;
				bullet_y <= gun_y;
				bullet_live <= !bullet_live && fire;
				if (bullet_live && !leaving) begin
					hit <= 1'b1;
					score <= score + 1'b1;
				end
			end
		end
	end

	assign win = (score == SCORE_W'(WIN_SCORE));

endmodule

`default_nettype wire

// File: src/frame_renderer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_renderer import tank_pkg::*; #(
	parameter int FRAME_CYCLES = 833333
) (
	input wire CLOCK_50,
	input wire reset,
	input wire [NUM_PLAYERS-1:0][COORD_W-1:0] tank_x,
	input wire [NUM_PLAYERS-1:0][COORD_W-1:0] tank_y,
	input wire [NUM_PLAYERS-1:0][COORD_W-1:0] bullet_x,
	input wire [NUM_PLAYERS-1:0][COORD_W-1:0] bullet_y,
	input wire [NUM_PLAYERS-1:0] bullet_live,
	input wire [NUM_PLAYERS-1:0] hit,
	input wire [NUM_PLAYERS-1:0] win,
	output logic step,
	output logic new_game,
	output logic [COORD_W-1:0] pix_x,
	output logic [COORD_W-1:0] pix_y,
	output logic [COLOUR_W-1:0] pix_colour,
	output logic plot
);

	localparam int TICK_W = $clog2(FRAME_CYCLES);

	render_state_t state;
	logic [TICK_W-1:0] frame_cnt;
	logic tick;
	logic [COORD_W-1:0] wx, wy;
	logic spr_player;	// 0 right, 1 left
	logic [1:0] spr_kind;	// 0 tank, 1 gun, 2 bullet
	logic [COORD_W-1:0] org_x, org_y, spr_w, spr_h;
	logic [COLOUR_W-1:0] colour;
	logic last_col, last_row, pass_last, nxt_player, abort;
	logic [1:0] nxt_kind;

	assign tick = (frame_cnt == TICK_W'(FRAME_CYCLES - 1));

	always_ff @(posedge CLOCK_50) begin
		if (reset || tick)
			frame_cnt <= '0;
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	always_comb begin
		org_x = '0;
		org_y = '0;
		spr_w = COORD_W'(SCREEN_W);
		spr_h = COORD_W'(SCREEN_H);
		colour = COLOUR_BLACK;
		if (state != CLEAR) begin
			case (spr_kind)
				2'd0: {org_x, org_y, spr_w, spr_h} = {tank_x[spr_player], tank_y[spr_player],
					COORD_W'(TANK_W), COORD_W'(TANK_H)};
				2'd1: begin
					org_x = COORD_W'(int'(tank_x[spr_player]) + GUN_DX[spr_player]);
					org_y = COORD_W'(int'(tank_y[spr_player]) + GUN_DY[spr_player]);
					spr_w = COORD_W'(GUN_W);
					spr_h = COORD_W'(GUN_H);
				end
				default: {org_x, org_y, spr_w, spr_h} = {bullet_x[spr_player],
					bullet_y[spr_player], COORD_W'(BULLET_W), COORD_W'(BULLET_H)};
			endcase
			if (state == DRAW)
				colour = (spr_kind != 2'd2 && hit[~spr_player]) ? COLOUR_HIT
					: PLAYER_COLOUR[spr_player];
		end
	end

	// Sprite order within a pass, idle bullets skipped
	always_comb begin
		last_col = (wx == spr_w - 1'b1);
		last_row = (wy == spr_h - 1'b1);
		nxt_player = spr_player;
		nxt_kind = spr_kind + 2'd1;
		pass_last = 1'b0;
		if (spr_kind == 2'd2 || (spr_kind == 2'd1 && !bullet_live[spr_player])) begin
			nxt_player = 1'b1;
			nxt_kind = 2'd0;
			pass_last = spr_player;
		end
	end

	assign abort = (state == DRAW) && (|win);	// Game over, wipe instead of drawing
	assign step = (state == STEP);
	assign new_game = (state == CLEAR) && last_col && last_row;

	always_ff @(posedge CLOCK_50) begin
		if (reset || abort) begin
			state <= CLEAR;
			wx <= '0;
			wy <= '0;
			spr_player <= 1'b0;
			spr_kind <= 2'd0;
		end else begin
			case (state)
				IDLE: if (tick) state <= ERASE;
				STEP: state <= DRAW;
				CLEAR, ERASE, DRAW: begin
					wx <= last_col ? '0 : wx + 1'b1;
					if (last_col) begin
						wy <= last_row ? '0 : wy + 1'b1;
						if (last_row) begin
							if (state == CLEAR) begin
								state <= DRAW;
							end else if (pass_last) begin
								spr_player <= 1'b0;
								spr_kind <= 2'd0;
								state <= (state == ERASE) ? STEP : IDLE;
							end else begin
								spr_player <= nxt_player;
								spr_kind <= nxt_kind;
							end
						end
					end
				end
				default: state <= CLEAR;
			endcase
		end
	end

	always_ff @(posedge CLOCK_50) begin
		pix_x <= org_x + wx;
		pix_y <= org_y + wy;
		pix_colour <= colour;
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset)
			plot <= 1'b0;
		else
			plot <= (state == CLEAR) || (state == ERASE) || (state == DRAW && !abort);
	end

endmodule

`default_nettype wire

// File: src/tank_duel_top.sv
`timescale 1ns/10ps
`default_nettype none

module tank_duel_top import tank_pkg::*; #(
	parameter int FRAME_CYCLES = 833333	// About 60 frames/s at 50 MHz
) (
	input wire CLOCK_50,
	input wire reset,
	input wire key_req,
	input wire [KEY_W-1:0] key_code,
	output logic key_ack,
	output logic [COORD_W-1:0] pix_x,
	output logic [COORD_W-1:0] pix_y,
	output logic [COLOUR_W-1:0] pix_colour,
	output logic plot,
	output logic [SCORE_W-1:0] score_right,
	output logic [SCORE_W-1:0] score_left
);

	move_t [NUM_PLAYERS-1:0] move;
	logic [NUM_PLAYERS-1:0] fire;
	logic step, new_game;
	logic [NUM_PLAYERS-1:0][COORD_W-1:0] tank_x, tank_y, bullet_x, bullet_y;
	logic [NUM_PLAYERS-1:0] bullet_live, hit, win;
	logic [NUM_PLAYERS-1:0][SCORE_W-1:0] score;

	key_decoder u_keys (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.key_req(key_req),
		.key_code(key_code),
		.step(step),
		.key_ack(key_ack),
		.move(move),
		.fire(fire)
	);

	genvar p;
	generate
		for (p = 0; p < NUM_PLAYERS; p++) begin : g_player
			tank_player #(.PLAYER(p)) u_player (
				.CLOCK_50(CLOCK_50),
				.reset(reset),
				.step(step),
				.new_game(new_game),
				.move(move[p]),
				.fire(fire[p]),
				.opp_x(tank_x[NUM_PLAYERS-1-p]),	// The other player's tank
				.opp_y(tank_y[NUM_PLAYERS-1-p]),
				.tank_x(tank_x[p]),
				.tank_y(tank_y[p]),
				.bullet_x(bullet_x[p]),
				.bullet_y(bullet_y[p]),
				.bullet_live(bullet_live[p]),
				.hit(hit[p]),
				.score(score[p]),
				.win(win[p])
			);
		end
	endgenerate

	frame_renderer #(.FRAME_CYCLES(FRAME_CYCLES)) u_render (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.tank_x(tank_x),
		.tank_y(tank_y),
		.bullet_x(bullet_x),
		.bullet_y(bullet_y),
		.bullet_live(bullet_live),
		.hit(hit),
		.win(win),
		.step(step),
		.new_game(new_game),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.pix_colour(pix_colour),
		.plot(plot)
	);

	assign score_right = score[0];
	assign score_left = score[1];

endmodule

`default_nettype wire

// File: sim/tb_tank_duel.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tank_duel import tank_pkg::*; ();

	localparam int FRAME_TIMEOUT = 25000;	// Cycles to cover a full clear and a pass
	localparam int ACK_TIMEOUT = 20;
	localparam int SPRITES_0 = TANK_W * TANK_H + GUN_W * GUN_H;	// Tank and gun pixels
	localparam int MAX_PASS = 2 * (SPRITES_0 + BULLET_W * BULLET_H);

	logic CLOCK_50 = 1'b0;
	logic reset;
	logic key_req;
	logic [KEY_W-1:0] key_code;
	logic key_ack, plot;
	logic [COORD_W-1:0] pix_x, pix_y;
	logic [COLOUR_W-1:0] pix_colour;
	logic [SCORE_W-1:0] score_right, score_left;

	int seed = 32'he203_87ef;

	// Pixel monitor state
	logic [COORD_W-1:0] run_x [MAX_PASS];
	logic [COORD_W-1:0] run_y [MAX_PASS];
	logic [COLOUR_W-1:0] run_c [MAX_PASS];
	int run_len = 0;
	int clear_len = 0;
	int clears = 0;
	int draws = 0;
	logic in_clear = 1'b0;
	int seen_x [NUM_PLAYERS];
	int seen_y [NUM_PLAYERS];
	int seen_c [NUM_PLAYERS];

	always #10 CLOCK_50 = ~CLOCK_50;

	tank_duel_top #(.FRAME_CYCLES(400)) DUT (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.key_req(key_req),
		.key_code(key_code),
		.key_ack(key_ack),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.pix_colour(pix_colour),
		.plot(plot),
		.score_right(score_right),
		.score_left(score_left)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		assert (got == expected) else
			abort_run($sformatf("CHECK FAILED at %0t: %s = %0d, expected %0d",
				$time, name, got, expected));
	endtask

	task automatic decode_draw_pass();
		int second;
		assert (run_len >= 2 * SPRITES_0 && run_len <= MAX_PASS &&
			(run_len - 2 * SPRITES_0) % (BULLET_W * BULLET_H) == 0) else
			abort_run($sformatf("Draw pass of %0d pixels has an impossible length", run_len));
		second = SPRITES_0;
		// A live bullet 0 wraps to its second row after 4 pixels
		if (run_y[second + BULLET_W] != run_y[second])
			second += BULLET_W * BULLET_H;
		seen_x[0] = run_x[0];
		seen_y[0] = run_y[0];
		seen_c[0] = run_c[0];
		seen_x[1] = run_x[second];
		seen_y[1] = run_y[second];
		seen_c[1] = run_c[second];
		draws++;
	endtask

	always @(negedge CLOCK_50) begin
		if (!reset) begin
			if (plot && pix_colour != COLOUR_BLACK) begin
				if (run_len < MAX_PASS) begin
					run_x[run_len] = pix_x;
					run_y[run_len] = pix_y;
					run_c[run_len] = pix_colour;
				end
				run_len++;
			end else if (run_len > 0) begin
				decode_draw_pass();
				run_len = 0;
			end
			// Only a clear starts at the screen origin
			if (plot && pix_colour == COLOUR_BLACK &&
				(in_clear || (pix_x == 0 && pix_y == 0))) begin
				check_value("pix_x in clear", pix_x, clear_len % SCREEN_W);
				check_value("pix_y in clear", pix_y, clear_len / SCREEN_W);
				in_clear = 1'b1;
				clear_len++;
			end else if (in_clear) begin
				check_value("clear pixel count", clear_len, SCREEN_W * SCREEN_H);
				clears++;
				in_clear = 1'b0;
				clear_len = 0;
			end
		end
	end

	task automatic wait_draw();
		int target;
		int cycles;
		target = draws + 1;
		cycles = 0;
		while (draws < target && cycles < FRAME_TIMEOUT) begin
			@(posedge CLOCK_50);
			cycles++;
		end
		assert (draws >= target) else
			abort_run("Timed out waiting for a DRAW pass");
	endtask

	task automatic send_key(input int code);
		int gap;
		int cycles;
		gap = $unsigned($random(seed)) % 16;
		repeat (gap) @(negedge CLOCK_50);
		@(negedge CLOCK_50);
		assert (!key_ack) else abort_run("key_ack was high before key_req rose");
		key_code = KEY_W'(code);
		key_req = 1'b1;
		cycles = 0;
		while (!key_ack && cycles < ACK_TIMEOUT) begin
			@(negedge CLOCK_50);
			cycles++;
		end
		assert (key_ack) else abort_run("key_ack never rose after key_req");
		key_req = 1'b0;
		cycles = 0;
		while (key_ack && cycles < ACK_TIMEOUT) begin
			@(negedge CLOCK_50);
			cycles++;
		end
		assert (!key_ack) else abort_run("key_ack stayed high after key_req fell");
	endtask

	initial begin
		int fd;
		int fields;
		int f;
		int code, frames;
		int e_x0, e_y0, e_x1, e_y1, e_sr, e_sl, e_c0, e_c1;
		string line;
		reset = 1'b1;
		key_req = 1'b0;
		key_code = '0;
		repeat (5) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		reset = 1'b0;
		check_value("plot", plot, 0);
		check_value("key_ack", key_ack, 0);
		check_value("score_right", score_right, 0);
		check_value("score_left", score_left, 0);
		wait_draw();
		check_value("clear passes", clears, 1);

		fd = $fopen("sim/tank_duel_cases.txt", "r");
		assert (fd != 0) else abort_run("Cannot open sim/tank_duel_cases.txt");
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 4 || line[0] == "#")
				continue;
			fields = $sscanf(line, "%h %d %d %d %d %d %d %d %d %d", code, frames,
				e_x0, e_y0, e_x1, e_y1, e_sr, e_sl, e_c0, e_c1);
			assert (fields == 10) else abort_run({"Malformed line in case file: ", line});
			for (f = 0; f < frames; f++) begin
				if (code != 0)
					send_key(code);	// Key repeats before every frame
				wait_draw();
			end
			check_value("right tank x", seen_x[0], e_x0);
			check_value("right tank y", seen_y[0], e_y0);
			check_value("left tank x", seen_x[1], e_x1);
			check_value("left tank y", seen_y[1], e_y1);
			check_value("score_right", score_right, e_sr);
			check_value("score_left", score_left, e_sl);
			check_value("right tank colour", seen_c[0], e_c0);
			check_value("left tank colour", seen_c[1], e_c1);
		end
		$fclose(fd);
		check_value("clear passes", clears, 2);	// Reset clear plus the end of game
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/tank_duel_cases.txt
# key(hex, 00 none) frames right_x right_y left_x left_y score_right score_left right_colour left_colour
# A key is sent again before each frame, the check uses the last DRAW pass
00 0 144 50 8 50 0 0 3 1
7f 2 144 50 8 50 0 0 3 1
12 25 123 50 8 50 0 0 3 1
14 25 144 50 8 50 0 0 3 1
64 25 144 50 30 50 0 0 3 1
61 25 144 50 8 50 0 0 3 1
11 45 144 10 8 50 0 0 3 1
13 95 144 100 8 50 0 0 3 1
11 50 144 50 8 50 0 0 3 1
77 10 144 50 8 40 0 0 3 1
15 1 144 50 8 40 0 0 3 1
00 71 144 50 8 40 0 0 3 1
73 10 144 50 8 50 0 0 3 1
66 1 144 50 8 50 0 0 3 1
00 58 144 50 8 50 0 0 3 1
00 1 144 50 8 50 0 1 5 1
00 1 144 50 8 50 0 1 3 1
15 59 144 50 8 50 0 1 3 1
15 1 144 50 8 50 1 1 3 5
15 360 144 50 8 50 0 0 3 1

// File: filelist.f
src/tank_pkg.sv
src/key_decoder.sv
src/tank_player.sv
src/frame_renderer.sv
src/tank_duel_top.sv
sim/tb_tank_duel.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_tank_duel
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
PASS_TEXT = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
